// ==== logic/shell_pkg.sv ====
// NoC block shell definitions
// Stream word, settings bus and stream ID types, packet type and
// readback select encodings, register addresses and field positions
package shell_pkg;

   typedef logic [63:0] word_t;
   typedef logic [7:0]  sr_addr_t;
   typedef logic [31:0] sr_data_t;
   typedef logic [15:0] sid_t;
   typedef logic [11:0] seqnum_t;

   // Packet type, header bits 63:62
   typedef enum logic [1:0] {
      PKT_DATA = 2'd0,
      PKT_FC   = 2'd1,
      PKT_CMD  = 2'd2,
      PKT_ACK  = 2'd3
   } pkt_type_e;

   // Shell readback select
   typedef enum logic [2:0] {
      RB_NOC_ID          = 3'd0,
      RB_GLOBAL_PARAMS   = 3'd1,
      RB_BLOCK_PORT_SIDS = 3'd4,
      RB_USER_RB_DATA    = 3'd7
   } rb_sel_e;

   // Settings register addresses
   localparam sr_addr_t SR_RB_ADDR      = 8'd124;
   localparam sr_addr_t SR_RB_ADDR_USER = 8'd125;
   localparam sr_addr_t SR_SRC_SID      = 8'd128;
   localparam sr_addr_t SR_NEXT_DST_SID = 8'd130;

   // Header field positions
   localparam int HDR_TYPE_LSB = 62;
   localparam int HDR_SEQ_LSB  = 48;
   localparam int HDR_SRC_LSB  = 32;
   localparam int HDR_DST_LSB  = 16;

   // Command payload field positions
   localparam int PLD_ADDR_LSB = 32;
   localparam int PLD_DATA_LSB = 0;

   localparam word_t BAD_READBACK = 64'h0BADC0DE0BADC0DE;

   // One input port, one output port
   localparam word_t GLOBAL_PARAMS_VALUE = {48'd0, 3'd0, 5'd1, 3'd0, 5'd1};

endpackage

// ==== logic/axis_if.sv ====
// Block shell interfaces
// axis_if carries one 64-bit packet stream with valid/ready handshake
// set_bus_if carries the settings bus and the readback word
`timescale 1ns/1ps

interface axis_if;
   shell_pkg::word_t tdata;
   logic             tlast;
   logic             tvalid;
   logic             tready;

   modport source (output tdata, output tlast, output tvalid, input tready);
   modport sink   (input tdata, input tlast, input tvalid, output tready);
endinterface

interface set_bus_if;
   logic                stb;
   shell_pkg::sr_addr_t addr;
   shell_pkg::sr_data_t data;
   shell_pkg::word_t    rb_data;

   // Command processor side
   modport ctrl (output stb, output addr, output data, input rb_data);
   // Register block side
   modport regs (input stb, input addr, input data, output rb_data);
endinterface

// ==== logic/packet_type_demux.sv ====
// Packet type demux
// Steers each incoming packet by the type field of its first word.
// Data goes to the stream sink, commands to the command processor,
// acks to the ack-in port; flow control packets are drained
`timescale 1ns/1ps

module packet_type_demux (
   input  logic   clk,
   input  logic   reset,
   axis_if.sink   i_in,
   axis_if.source o_data,
   axis_if.source o_cmd,
   axis_if.source o_ack
);

   logic                 in_pkt;
   shell_pkg::pkt_type_e dest_q;
   shell_pkg::pkt_type_e hdr_type;
   shell_pkg::pkt_type_e cur_type;
   logic                 xfer;

   // Type of the word at the input when it starts a packet
   assign hdr_type = shell_pkg::pkt_type_e'(i_in.tdata[shell_pkg::HDR_TYPE_LSB +: 2]);
   assign cur_type = in_pkt ? dest_q : hdr_type;
   assign xfer     = i_in.tvalid && i_in.tready;

   // Payload fans out unregistered, only valid is steered
   assign o_data.tdata = i_in.tdata;
   assign o_data.tlast = i_in.tlast;
   assign o_cmd.tdata  = i_in.tdata;
   assign o_cmd.tlast  = i_in.tlast;
   assign o_ack.tdata  = i_in.tdata;
   assign o_ack.tlast  = i_in.tlast;

   assign o_data.tvalid = i_in.tvalid && (cur_type == shell_pkg::PKT_DATA);
   assign o_cmd.tvalid  = i_in.tvalid && (cur_type == shell_pkg::PKT_CMD);
   assign o_ack.tvalid  = i_in.tvalid && (cur_type == shell_pkg::PKT_ACK);

   // Ready comes from the selected output
   always_comb begin
      case (cur_type)
         shell_pkg::PKT_DATA: i_in.tready = o_data.tready;
         shell_pkg::PKT_FC:   i_in.tready = 1'b1;
         shell_pkg::PKT_CMD:  i_in.tready = o_cmd.tready;
         default:             i_in.tready = o_ack.tready;
      endcase
   end

   ////////////////////////////////////////
   // In-packet tracking
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         in_pkt <= 1'b0;
         dest_q <= shell_pkg::PKT_DATA;
      end else if (xfer) begin
         if (i_in.tlast) begin
            in_pkt <= 1'b0;
         end else if (!in_pkt) begin
            // First word of a multi-word packet, hold its type
            in_pkt <= 1'b1;
            dest_q <= hdr_type;
         end
      end
   end

endmodule

// ==== logic/cmd_packet_proc.sv ====
// Command packet processor
// Takes two-word command packets, issues one settings bus write per
// command, waits for the registered readback and returns a two-word
// ack packet holding the readback word
`timescale 1ns/1ps

module cmd_packet_proc (
   input  logic     clk,
   input  logic     reset,
   axis_if.sink     i_cmd,
   axis_if.source   o_resp,
   set_bus_if.ctrl  o_set
);

   typedef enum logic [2:0] {
      IDLE,
      PAYLOAD,
      STROBE,
      WAIT_RB,
      RESP_HDR,
      RESP_DATA
   } state_e;

   state_e              state;
   logic                rb_wait;
   logic                set_stb;
   shell_pkg::sr_addr_t set_addr;
   shell_pkg::sr_data_t set_data;
   shell_pkg::seqnum_t  seqnum;
   shell_pkg::sid_t     cmd_src_sid;
   shell_pkg::sid_t     cmd_dst_sid;
   shell_pkg::word_t    rb_word;
   shell_pkg::word_t    resp_hdr;
   logic                cmd_xfer;
   logic                resp_xfer;

   // New commands only while no response is pending
   assign i_cmd.tready = (state == IDLE) || (state == PAYLOAD);
   assign cmd_xfer     = i_cmd.tvalid && i_cmd.tready;
   assign resp_xfer    = o_resp.tvalid && o_resp.tready;

   assign o_set.stb  = set_stb;
   assign o_set.addr = set_addr;
   assign o_set.data = set_data;

   // Response header, SIDs swapped back toward the sender
   always_comb begin
      resp_hdr = '0;
      resp_hdr[shell_pkg::HDR_TYPE_LSB +: 2] = shell_pkg::PKT_ACK;
      resp_hdr[shell_pkg::HDR_SEQ_LSB +: $bits(shell_pkg::seqnum_t)] = seqnum;
      resp_hdr[shell_pkg::HDR_SRC_LSB +: $bits(shell_pkg::sid_t)] = cmd_dst_sid;
      resp_hdr[shell_pkg::HDR_DST_LSB +: $bits(shell_pkg::sid_t)] = cmd_src_sid;
   end

   assign o_resp.tvalid = (state == RESP_HDR) || (state == RESP_DATA);
   assign o_resp.tlast  = (state == RESP_DATA);
   assign o_resp.tdata  = (state == RESP_DATA) ? rb_word : resp_hdr;

   ////////////////////////////////////////
   // Control FSM
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         state   <= IDLE;
         set_stb <= 1'b0;
         rb_wait <= 1'b0;
      end else begin
         set_stb <= 1'b0;
         case (state)
            IDLE: begin
               if (cmd_xfer) begin
                  state <= PAYLOAD;
               end
            end
            PAYLOAD: begin
               if (cmd_xfer) begin
                  state   <= STROBE;
                  set_stb <= 1'b1;
               end
            end
            STROBE: begin
               state   <= WAIT_RB;
               rb_wait <= 1'b0;
            end
            WAIT_RB: begin
               // Registers update on the strobe edge, readback one edge later
               rb_wait <= 1'b1;
               if (rb_wait) begin
                  state <= RESP_HDR;
               end
            end
            RESP_HDR: begin
               if (resp_xfer) begin
                  state <= RESP_DATA;
               end
            end
            RESP_DATA: begin
               if (resp_xfer) begin
                  state <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   ////////////////////////////////////////
   // Header, payload and readback capture
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      if ((state == IDLE) && cmd_xfer) begin
         seqnum      <= i_cmd.tdata[shell_pkg::HDR_SEQ_LSB +: $bits(shell_pkg::seqnum_t)];
         cmd_src_sid <= i_cmd.tdata[shell_pkg::HDR_SRC_LSB +: $bits(shell_pkg::sid_t)];
         cmd_dst_sid <= i_cmd.tdata[shell_pkg::HDR_DST_LSB +: $bits(shell_pkg::sid_t)];
      end
      if ((state == PAYLOAD) && cmd_xfer) begin
         set_addr <= i_cmd.tdata[shell_pkg::PLD_ADDR_LSB +: $bits(shell_pkg::sr_addr_t)];
         set_data <= i_cmd.tdata[shell_pkg::PLD_DATA_LSB +: $bits(shell_pkg::sr_data_t)];
      end
      if ((state == WAIT_RB) && rb_wait) begin
         rb_word <= o_set.rb_data;
      end
   end

endmodule

// ==== logic/shell_registers.sv ====
// Shell setting registers
// Holds source SID, next destination SID, readback select and user
// readback address, and registers the readback mux output
`timescale 1ns/1ps

module shell_registers #(
   parameter logic [63:0] NOC_ID = 64'h0
) (
   input  logic                clk,
   input  logic                reset,
   set_bus_if.regs             i_set,
   input  shell_pkg::word_t    i_rb_data,
   output shell_pkg::sr_addr_t o_rb_addr,
   output shell_pkg::sid_t     o_src_sid,
   output shell_pkg::sid_t     o_next_dst_sid
);

   shell_pkg::rb_sel_e  rb_sel;
   shell_pkg::sr_addr_t rb_addr_user;
   shell_pkg::sid_t     src_sid;
   shell_pkg::sid_t     next_dst_sid;

   assign o_rb_addr      = rb_addr_user;
   assign o_src_sid      = src_sid;
   assign o_next_dst_sid = next_dst_sid;

   ////////////////////////////////////////
   // Register writes
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         rb_sel       <= shell_pkg::RB_NOC_ID;
         rb_addr_user <= '0;
         src_sid      <= '0;
         next_dst_sid <= '0;
      end else if (i_set.stb) begin
         case (i_set.addr)
            shell_pkg::SR_RB_ADDR: begin
               // Low 3 bits pick the shell readback source
               rb_sel <= shell_pkg::rb_sel_e'(i_set.data[2:0]);
            end
            shell_pkg::SR_RB_ADDR_USER: begin
               rb_addr_user <= i_set.data[$bits(shell_pkg::sr_addr_t)-1:0];
            end
            shell_pkg::SR_SRC_SID: begin
               src_sid <= i_set.data[$bits(shell_pkg::sid_t)-1:0];
            end
            shell_pkg::SR_NEXT_DST_SID: begin
               next_dst_sid <= i_set.data[$bits(shell_pkg::sid_t)-1:0];
            end
            default: begin
               // Addresses for user registers, nothing held here
            end
         endcase
      end
   end

   ////////////////////////////////////////
   // Readback mux
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      case (rb_sel)
         shell_pkg::RB_NOC_ID: begin
            i_set.rb_data <= NOC_ID;
         end
         shell_pkg::RB_GLOBAL_PARAMS: begin
            i_set.rb_data <= shell_pkg::GLOBAL_PARAMS_VALUE;
         end
         shell_pkg::RB_BLOCK_PORT_SIDS: begin
            i_set.rb_data <= {src_sid, next_dst_sid, 32'd0};
         end
         shell_pkg::RB_USER_RB_DATA: begin
            i_set.rb_data <= i_rb_data;
         end
         default: begin
            i_set.rb_data <= shell_pkg::BAD_READBACK;
         end
      endcase
   end

endmodule

// ==== logic/output_arbiter.sv ====
// Output arbiter
// Merges command responses and stream source packets onto one
// stream; a grant covers a whole packet, priority alternates on release
`timescale 1ns/1ps

module output_arbiter (
   input  logic   clk,
   input  logic   reset,
   axis_if.sink   i_resp,
   axis_if.sink   i_src,
   axis_if.source o_out
);

   typedef enum logic [1:0] {
      GRANT_NONE,
      GRANT_RESP,
      GRANT_SRC
   } grant_e;

   grant_e grant;
   logic   last_src;
   logic   out_xfer;

   assign out_xfer = o_out.tvalid && o_out.tready;

   // Output mux follows the registered grant
   always_comb begin
      o_out.tdata   = i_resp.tdata;
      o_out.tlast   = i_resp.tlast;
      o_out.tvalid  = 1'b0;
      i_resp.tready = 1'b0;
      i_src.tready  = 1'b0;
      case (grant)
         GRANT_RESP: begin
            o_out.tvalid  = i_resp.tvalid;
            i_resp.tready = o_out.tready;
         end
         GRANT_SRC: begin
            o_out.tdata  = i_src.tdata;
            o_out.tlast  = i_src.tlast;
            o_out.tvalid = i_src.tvalid;
            i_src.tready = o_out.tready;
         end
         default: begin
         end
      endcase
   end

   ////////////////////////////////////////
   // Grant state
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         grant    <= GRANT_NONE;
         last_src <= 1'b1;
      end else begin
         case (grant)
            GRANT_NONE: begin
               // Loser of the last round goes first
               if (i_resp.tvalid && (!i_src.tvalid || last_src)) begin
                  grant <= GRANT_RESP;
               end else if (i_src.tvalid) begin
                  grant <= GRANT_SRC;
               end
            end
            GRANT_RESP: begin
               if (out_xfer && o_out.tlast) begin
                  grant    <= GRANT_NONE;
                  last_src <= 1'b0;
               end
            end
            GRANT_SRC: begin
               if (out_xfer && o_out.tlast) begin
                  grant    <= GRANT_NONE;
                  last_src <= 1'b1;
               end
            end
            default: grant <= GRANT_NONE;
         endcase
      end
   end

endmodule

// ==== logic/noc_shell_top.sv ====
// NoC block shell top level
// Splits the network stream by packet type, runs settings commands
// against the shell registers and merges responses with the user's
// stream source onto the network output
`timescale 1ns/1ps

module noc_shell_top #(
   parameter logic [63:0] NOC_ID = 64'hDEAD_BEEF_0123_4567
) (
   input  logic                clk,
   input  logic                reset,
   // Network in
   input  shell_pkg::word_t    i_net_tdata,
   input  logic                i_net_tlast,
   input  logic                i_net_tvalid,
   output logic                o_net_tready,
   // Network out
   output shell_pkg::word_t    o_net_tdata,
   output logic                o_net_tlast,
   output logic                o_net_tvalid,
   input  logic                i_net_tready,
   // Stream sink
   output shell_pkg::word_t    o_sink_tdata,
   output logic                o_sink_tlast,
   output logic                o_sink_tvalid,
   input  logic                i_sink_tready,
   // Stream source
   input  shell_pkg::word_t    i_src_tdata,
   input  logic                i_src_tlast,
   input  logic                i_src_tvalid,
   output logic                o_src_tready,
   // Ack in
   output shell_pkg::word_t    o_ackin_tdata,
   output logic                o_ackin_tlast,
   output logic                o_ackin_tvalid,
   input  logic                i_ackin_tready,
   // Settings bus and user readback
   output logic                o_set_stb,
   output shell_pkg::sr_addr_t o_set_addr,
   output shell_pkg::sr_data_t o_set_data,
   output shell_pkg::sr_addr_t o_rb_addr,
   input  shell_pkg::word_t    i_rb_data,
   output shell_pkg::sid_t     o_src_sid,
   output shell_pkg::sid_t     o_next_dst_sid
);

   axis_if    net_in ();
   axis_if    net_out ();
   axis_if    sink ();
   axis_if    ackin ();
   axis_if    cmd_in ();
   axis_if    resp_out ();
   axis_if    src_in ();
   set_bus_if set_bus ();

   ////////////////////////////////////////
   // Port to interface wiring
   ////////////////////////////////////////
   assign net_in.tdata   = i_net_tdata;
   assign net_in.tlast   = i_net_tlast;
   assign net_in.tvalid  = i_net_tvalid;
   assign o_net_tready   = net_in.tready;

   assign o_net_tdata    = net_out.tdata;
   assign o_net_tlast    = net_out.tlast;
   assign o_net_tvalid   = net_out.tvalid;
   assign net_out.tready = i_net_tready;

   assign o_sink_tdata   = sink.tdata;
   assign o_sink_tlast   = sink.tlast;
   assign o_sink_tvalid  = sink.tvalid;
   assign sink.tready    = i_sink_tready;

   assign src_in.tdata   = i_src_tdata;
   assign src_in.tlast   = i_src_tlast;
   assign src_in.tvalid  = i_src_tvalid;
   assign o_src_tready   = src_in.tready;

   assign o_ackin_tdata  = ackin.tdata;
   assign o_ackin_tlast  = ackin.tlast;
   assign o_ackin_tvalid = ackin.tvalid;
   assign ackin.tready   = i_ackin_tready;

   assign o_set_stb      = set_bus.stb;
   assign o_set_addr     = set_bus.addr;
   assign o_set_data     = set_bus.data;

   ////////////////////////////////////////
   // Blocks
   ////////////////////////////////////////
   packet_type_demux i_packet_type_demux (
      .clk    (clk),
      .reset  (reset),
      .i_in   (net_in.sink),
      .o_data (sink.source),
      .o_cmd  (cmd_in.source),
      .o_ack  (ackin.source)
   );

   cmd_packet_proc i_cmd_packet_proc (
      .clk    (clk),
      .reset  (reset),
      .i_cmd  (cmd_in.sink),
      .o_resp (resp_out.source),
      .o_set  (set_bus.ctrl)
   );

   shell_registers #(
      .NOC_ID (NOC_ID)
   ) i_shell_registers (
      .clk            (clk),
      .reset          (reset),
      .i_set          (set_bus.regs),
      .i_rb_data      (i_rb_data),
      .o_rb_addr      (o_rb_addr),
      .o_src_sid      (o_src_sid),
      .o_next_dst_sid (o_next_dst_sid)
   );

   output_arbiter i_output_arbiter (
      .clk    (clk),
      .reset  (reset),
      .i_resp (resp_out.sink),
      .i_src  (src_in.sink),
      .o_out  (net_out.source)
   );

endmodule

// ==== bench/tb_noc_shell.sv ====
// Testbench for the NoC block shell
// Sends data, flow control, ack and command packets on the network
// input, drives the stream source, tracks the shell registers and
// checks the sink, ack-in, settings bus and network output streams
`timescale 1ns/1ps

module tb_noc_shell;

   localparam logic [63:0] NOC_ID = 64'h1234_5678_9ABC_DEF0;
   localparam int TIMEOUT = 4000;

   typedef struct packed {
      logic             last;
      shell_pkg::word_t data;
   } beat_t;

   typedef struct packed {
      shell_pkg::word_t hdr;
      shell_pkg::word_t pld;
   } resp_t;

   typedef struct packed {
      shell_pkg::sr_addr_t addr;
      shell_pkg::sr_data_t data;
   } set_t;

   logic                clk;
   logic                reset;
   shell_pkg::word_t    i_net_tdata;
   logic                i_net_tlast;
   logic                i_net_tvalid;
   logic                o_net_tready;
   shell_pkg::word_t    o_net_tdata;
   logic                o_net_tlast;
   logic                o_net_tvalid;
   logic                i_net_tready;
   shell_pkg::word_t    o_sink_tdata;
   logic                o_sink_tlast;
   logic                o_sink_tvalid;
   logic                i_sink_tready;
   shell_pkg::word_t    i_src_tdata;
   logic                i_src_tlast;
   logic                i_src_tvalid;
   logic                o_src_tready;
   shell_pkg::word_t    o_ackin_tdata;
   logic                o_ackin_tlast;
   logic                o_ackin_tvalid;
   logic                i_ackin_tready;
   logic                o_set_stb;
   shell_pkg::sr_addr_t o_set_addr;
   shell_pkg::sr_data_t o_set_data;
   shell_pkg::sr_addr_t o_rb_addr;
   shell_pkg::word_t    i_rb_data;
   shell_pkg::sid_t     o_src_sid;
   shell_pkg::sid_t     o_next_dst_sid;

   // Expected traffic per output
   beat_t sink_q[$];
   beat_t ack_q[$];
   beat_t resp_q[$];
   beat_t src_q[$];
   set_t  set_q[$];

   // Shell register state as the testbench sees it
   logic [2:0]          model_rb_sel;
   shell_pkg::sr_addr_t model_rb_user;
   shell_pkg::sid_t     model_src_sid;
   shell_pkg::sid_t     model_dst_sid;

   logic stall_en;
   logic out_in_pkt;
   logic out_from_resp;

   noc_shell_top #(
      .NOC_ID (NOC_ID)
   ) i_noc_shell_top (.*);

   initial begin
      clk = 1'b0;
      forever begin
         #4 clk = ~clk;
      end
   end

   ////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////
   function automatic shell_pkg::word_t user_readback(shell_pkg::sr_addr_t addr);
      return {8{addr}};
   endfunction

   function automatic shell_pkg::word_t rand_word();
      return {$urandom, $urandom};
   endfunction

   function automatic void model_write(shell_pkg::sr_addr_t addr, shell_pkg::sr_data_t data);
      case (addr)
         shell_pkg::SR_RB_ADDR:      model_rb_sel  = data[2:0];
         shell_pkg::SR_RB_ADDR_USER: model_rb_user = data[7:0];
         shell_pkg::SR_SRC_SID:      model_src_sid = data[15:0];
         shell_pkg::SR_NEXT_DST_SID: model_dst_sid = data[15:0];
         default: begin
         end
      endcase
   endfunction

   // Ack header with swapped SIDs, payload from the readback select
   function automatic resp_t ref_response(shell_pkg::word_t cmd_hdr);
      resp_t r;
      r.hdr = '0;
      r.hdr[63:62] = 2'd3;
      r.hdr[59:48] = cmd_hdr[59:48];
      r.hdr[47:32] = cmd_hdr[31:16];
      r.hdr[31:16] = cmd_hdr[47:32];
      case (model_rb_sel)
         3'd0:    r.pld = NOC_ID;
         3'd1:    r.pld = 64'h0000_0000_0000_0101;
         3'd4:    r.pld = {model_src_sid, model_dst_sid, 32'd0};
         3'd7:    r.pld = user_readback(model_rb_user);
         default: r.pld = 64'h0BAD_C0DE_0BAD_C0DE;
      endcase
      return r;
   endfunction

   ////////////////////////////////////////
   // Error reporting and compares
   ////////////////////////////////////////
   task automatic fail_now(string msg);
      $display("** FAIL **");
      $display("%s", msg);
      $fatal(1, "stopped at first error");
   endtask

   task automatic compare_word(string name, shell_pkg::word_t got, shell_pkg::word_t exp);
      if (got !== exp) begin
         fail_now($sformatf("mismatch %s: got %h expected %h", name, got, exp));
      end
   endtask

   task automatic compare_bit(string name, logic got, logic exp);
      if (got !== exp) begin
         fail_now($sformatf("mismatch %s: got %h expected %h", name, got, exp));
      end
   endtask

   task automatic compare_addr(string name, shell_pkg::sr_addr_t got,
                               shell_pkg::sr_addr_t exp);
      if (got !== exp) begin
         fail_now($sformatf("mismatch %s: got %h expected %h", name, got, exp));
      end
   endtask

   task automatic compare_data(string name, shell_pkg::sr_data_t got,
                               shell_pkg::sr_data_t exp);
      if (got !== exp) begin
         fail_now($sformatf("mismatch %s: got %h expected %h", name, got, exp));
      end
   endtask

   task automatic compare_sid(string name, shell_pkg::sid_t got, shell_pkg::sid_t exp);
      if (got !== exp) begin
         fail_now($sformatf("mismatch %s: got %h expected %h", name, got, exp));
      end
   endtask

   ////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////
   // Readies and user readback change just after each rising edge
   initial begin
      forever begin
         @(posedge clk);
         #1;
         i_rb_data      = user_readback(o_rb_addr);
         i_net_tready   = !stall_en || ($urandom_range(3) != 0);
         i_sink_tready  = !stall_en || ($urandom_range(3) != 0);
         i_ackin_tready = !stall_en || ($urandom_range(3) != 0);
      end
   end

   // Entered 1 ns after an edge, returns 1 ns after the transfer edge
   task automatic put_net_word(shell_pkg::word_t data, logic last);
      int cycles;
      cycles       = 0;
      i_net_tdata  = data;
      i_net_tlast  = last;
      i_net_tvalid = 1'b1;
      @(negedge clk);
      while (!o_net_tready) begin
         cycles++;
         if (cycles > TIMEOUT) begin
            fail_now("network input never became ready");
         end
         @(negedge clk);
      end
      @(posedge clk);
      #1;
      i_net_tvalid = 1'b0;
   endtask

   task automatic put_src_word(shell_pkg::word_t data, logic last);
      int cycles;
      cycles       = 0;
      i_src_tdata  = data;
      i_src_tlast  = last;
      i_src_tvalid = 1'b1;
      @(negedge clk);
      while (!o_src_tready) begin
         cycles++;
         if (cycles > TIMEOUT) begin
            fail_now("stream source never became ready");
         end
         @(negedge clk);
      end
      @(posedge clk);
      #1;
      i_src_tvalid = 1'b0;
   endtask

   task automatic send_net_packet(logic [1:0] ptype, int len);
      shell_pkg::word_t w;
      beat_t            b;
      for (int i = 0; i < len; i++) begin
         w = rand_word();
         if (i == 0) begin
            w[63:62] = ptype;
         end
         b.last = (i == len - 1);
         b.data = w;
         // Flow control has no expected output
         if (ptype == 2'd0) begin
            sink_q.push_back(b);
         end else if (ptype == 2'd3) begin
            ack_q.push_back(b);
         end
         put_net_word(w, b.last);
      end
   endtask

   task automatic send_src_packet(int len);
      beat_t b;
      for (int i = 0; i < len; i++) begin
         b.data = rand_word();
         b.last = (i == len - 1);
         // Data type in the first word tells it apart from an ack
         if (i == 0) begin
            b.data[63:62] = 2'd0;
         end
         src_q.push_back(b);
         put_src_word(b.data, b.last);
      end
   endtask

   task automatic send_command(shell_pkg::sr_addr_t addr, shell_pkg::sr_data_t data);
      shell_pkg::word_t hdr;
      shell_pkg::word_t pld;
      resp_t            exp;
      set_t             st;
      beat_t            b;
      hdr        = rand_word();
      hdr[63:62] = 2'd2;
      pld        = rand_word();
      pld[39:32] = addr;
      pld[31:0]  = data;
      st.addr    = addr;
      st.data    = data;
      set_q.push_back(st);
      model_write(addr, data);
      exp    = ref_response(hdr);
      b.last = 1'b0;
      b.data = exp.hdr;
      resp_q.push_back(b);
      b.last = 1'b1;
      b.data = exp.pld;
      resp_q.push_back(b);
      put_net_word(hdr, 1'b0);
      put_net_word(pld, 1'b1);
   endtask

   function automatic shell_pkg::sr_addr_t pick_cmd_addr();
      case ($urandom_range(4))
         0:       return shell_pkg::SR_RB_ADDR;
         1:       return shell_pkg::SR_RB_ADDR_USER;
         2:       return shell_pkg::SR_SRC_SID;
         3:       return shell_pkg::SR_NEXT_DST_SID;
         default: return 8'h33;
      endcase
   endfunction

   task automatic wait_for_drain();
      int cycles;
      cycles = 0;
      while (sink_q.size() != 0 || ack_q.size() != 0 || set_q.size() != 0 ||
             resp_q.size() != 0 || src_q.size() != 0) begin
         cycles++;
         if (cycles > TIMEOUT) begin
            fail_now("expected output never arrived");
         end
         @(posedge clk);
      end
      @(posedge clk);
      #1;
   endtask

   ////////////////////////////////////////
   // Output checking
   ////////////////////////////////////////
   // Sampled at the falling edge, where every handshake is settled
   always @(negedge clk) begin
      beat_t b;
      set_t  st;
      if (!reset) begin
         if (o_sink_tvalid && i_sink_tready) begin
            if (sink_q.size() == 0) begin
               fail_now("unexpected word on the stream sink");
            end else begin
               b = sink_q.pop_front();
               compare_word("o_sink_tdata", o_sink_tdata, b.data);
               compare_bit("o_sink_tlast", o_sink_tlast, b.last);
            end
         end
         if (o_ackin_tvalid && i_ackin_tready) begin
            if (ack_q.size() == 0) begin
               fail_now("unexpected word on the ack-in port");
            end else begin
               b = ack_q.pop_front();
               compare_word("o_ackin_tdata", o_ackin_tdata, b.data);
               compare_bit("o_ackin_tlast", o_ackin_tlast, b.last);
            end
         end
         if (o_set_stb) begin
            if (set_q.size() == 0) begin
               fail_now("settings strobe without a command");
            end else begin
               st = set_q.pop_front();
               compare_addr("o_set_addr", o_set_addr, st.addr);
               compare_data("o_set_data", o_set_data, st.data);
            end
         end
         if (o_net_tvalid && i_net_tready) begin
            // First word of a packet decides which source it came from
            if (!out_in_pkt) begin
               out_from_resp = (o_net_tdata[63:62] == 2'd3);
            end
            if (out_from_resp && resp_q.size() == 0) begin
               fail_now("response word on the network output with no command pending");
            end else if (!out_from_resp && src_q.size() == 0) begin
               fail_now("source word on the network output that was never sent");
            end else begin
               b = out_from_resp ? resp_q.pop_front() : src_q.pop_front();
               compare_word("o_net_tdata", o_net_tdata, b.data);
               compare_bit("o_net_tlast", o_net_tlast, b.last);
            end
            out_in_pkt = !o_net_tlast;
         end
      end
   end

   ////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////
   initial begin
      logic [1:0] ptype;
      void'($urandom(32'h1157a136));
      reset          = 1'b1;
      stall_en       = 1'b0;
      i_net_tdata    = '0;
      i_net_tlast    = 1'b0;
      i_net_tvalid   = 1'b0;
      i_net_tready   = 1'b1;
      i_sink_tready  = 1'b1;
      i_src_tdata    = '0;
      i_src_tlast    = 1'b0;
      i_src_tvalid   = 1'b0;
      i_ackin_tready = 1'b1;
      i_rb_data      = '0;
      model_rb_sel   = 3'd0;
      model_rb_user  = '0;
      model_src_sid  = '0;
      model_dst_sid  = '0;
      out_in_pkt     = 1'b0;
      out_from_resp  = 1'b0;
      repeat (10) @(posedge clk);
      #1;
      reset = 1'b0;

      compare_bit("o_net_tvalid", o_net_tvalid, 1'b0);
      compare_bit("o_sink_tvalid", o_sink_tvalid, 1'b0);
      compare_bit("o_ackin_tvalid", o_ackin_tvalid, 1'b0);
      compare_bit("o_set_stb", o_set_stb, 1'b0);
      compare_sid("o_src_sid", o_src_sid, 16'h0000);
      compare_sid("o_next_dst_sid", o_next_dst_sid, 16'h0000);
      compare_addr("o_rb_addr", o_rb_addr, 8'h00);

      // Type routing under random sink and ack-in stalls
      stall_en = 1'b1;
      repeat (30) begin
         case ($urandom_range(2))
            0:       ptype = 2'd0;
            1:       ptype = 2'd1;
            default: ptype = 2'd3;
         endcase
         send_net_packet(ptype, $urandom_range(1, 5));
      end
      wait_for_drain();

      // SID registers and block port readback
      send_command(shell_pkg::SR_SRC_SID, 32'h0000_A5C3);
      send_command(shell_pkg::SR_NEXT_DST_SID, 32'hFFFF_3C5A);
      send_command(8'h20, $urandom);
      wait_for_drain();
      compare_sid("o_src_sid", o_src_sid, model_src_sid);
      compare_sid("o_next_dst_sid", o_next_dst_sid, model_dst_sid);
      send_command(shell_pkg::SR_RB_ADDR, 32'd4);
      send_command(shell_pkg::SR_SRC_SID, 32'h0000_1E0F);
      wait_for_drain();
      compare_sid("o_src_sid", o_src_sid, model_src_sid);

      // Remaining readback selects
      send_command(shell_pkg::SR_RB_ADDR, 32'd0);
      send_command(shell_pkg::SR_RB_ADDR, 32'd1);
      send_command(shell_pkg::SR_RB_ADDR, 32'd3);
      send_command(shell_pkg::SR_RB_ADDR, 32'hFFFF_FFF6);
      send_command(shell_pkg::SR_RB_ADDR_USER, 32'h0000_005B);
      send_command(shell_pkg::SR_RB_ADDR, 32'd7);
      send_command(shell_pkg::SR_RB_ADDR_USER, 32'h0000_00C4);
      wait_for_drain();
      compare_addr("o_rb_addr", o_rb_addr, model_rb_user);

      // Source packets and commands competing for the network output
      fork
         begin
            repeat (16) send_src_packet($urandom_range(1, 6));
         end
         begin
            repeat (12) send_command(pick_cmd_addr(), $urandom);
         end
      join
      wait_for_drain();

      $display("** PASS **");
      $finish;
   end

endmodule

// ==== project.f ====
logic/shell_pkg.sv
logic/axis_if.sv
logic/packet_type_demux.sv
logic/cmd_packet_proc.sv
logic/shell_registers.sv
logic/output_arbiter.sv
logic/noc_shell_top.sv
bench/tb_noc_shell.sv

// ==== Makefile ====
# Verilator build and run for the NoC block shell
# Any variable below can be overridden on the make command line

VERILATOR  ?= verilator
TOP        ?= tb_noc_shell
RTL_TOP    ?= noc_shell_top
FILELIST   ?= project.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
TIMESCALE  ?= 1ns/1ps
PASS_TEXT  ?= ** PASS **
LINT_FLAGS ?= --lint-only --timing --timescale $(TIMESCALE)
SIM_FLAGS  ?= --binary --timing --timescale $(TIMESCALE)

.PHONY: all lint sim clean

all: sim

# Lint the RTL top level
lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

# Build and run the testbench, then look for the pass line in the log
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qF '$(PASS_TEXT)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
